//--- test/user_mux_cases.txt
// Columns: stream, len (bytes), address, wr, beats = (len - 1) / 8 + 1
// All values hex, one case per line
// Cases 0 to 3, one per stream, loaded while the request channel stalls
0 0008 00a0_0000_1000 0 1
1 0010 00a0_0001_2040 1 2
2 0019 00a0_0002_3080 0 4
3 0001 00a0_0003_40c0 1 1
// Cases 4 to 11, two full round-robin rounds
0 0020 00b1_0000_5000 1 4
1 0009 00b1_0001_6008 0 2
2 0018 00b1_0002_7010 1 3
3 0011 00b1_0003_8018 0 3
0 0004 00b1_0004_9020 0 1
1 0028 00b1_0005_a028 1 5
2 000f 00b1_0006_b030 0 2
3 0030 00b1_0007_c038 1 6
// Cases 12 to 21, more than the queue depth without responses
3 0008 00c2_0000_d000 0 1
1 0012 00c2_0001_e100 1 3
0 0010 00c2_0002_f200 0 2
2 0021 00c2_0003_0300 1 5
3 0007 00c2_0004_1400 0 1
1 0018 00c2_0005_2500 0 3
0 0040 00c2_0006_3600 1 8
2 0002 00c2_0007_4700 0 1
3 0019 00c2_0008_5800 1 4
0 000a 00c2_0009_6900 0 2

//--- sources.f
source/mux_pkg.sv
source/req_decode.sv
source/rr_arbiter.sv
source/seq_queue.sv
source/data_router.sv
source/user_mux_top.sv
test/tb_clock.sv
test/tb_user_mux.sv

//--- Bender.yml
package:
  name: user_mux

sources:
  # Design, package first
  - source/mux_pkg.sv
  - source/req_decode.sv
  - source/rr_arbiter.sv
  - source/seq_queue.sv
  - source/data_router.sv
  - source/user_mux_top.sv
  # Testbench
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_user_mux.sv

//--- test/tb_user_mux.sv
// Testbench of the request multiplexer
// Reads the request cases, drives the streams and the response data,
// models round-robin grants and response routing, checks the DUT
`timescale 1ns/1ps
`default_nettype none

module tb_user_mux;

  localparam int N_STREAMS     = 4;
  localparam int N_OUTSTANDING = 8;
  localparam int N_CASES       = 22;
  localparam int TIMEOUT       = 2000;

  logic                          aclk;
  logic                          aresetn;
  logic [N_STREAMS-1:0]          s_req_valid;
  logic [N_STREAMS-1:0]          s_req_ready;
  mux_pkg::req_t [N_STREAMS-1:0] s_req_data;
  logic                          m_req_valid;
  logic                          m_req_ready;
  mux_pkg::req_t                 m_req_data;
  logic                          s_rsp_valid;
  logic                          s_rsp_ready;
  mux_pkg::data_t                s_rsp_data;
  logic [N_STREAMS-1:0]          m_rsp_valid;
  logic [N_STREAMS-1:0]          m_rsp_ready;
  logic [N_STREAMS-1:0]          m_rsp_last;
  mux_pkg::data_t                m_rsp_data;

  // Five words per case: stream, len, address, wr, beats
  logic [47:0]   case_mem [5*N_CASES];
  // Case indices per stream, in file order
  int            sc [N_STREAMS][N_CASES];
  int            n_sc [N_STREAMS];
  // Positions in sc: driven, taken by decode, granted
  int            send_pos [N_STREAMS];
  int            acc_pos [N_STREAMS];
  int            gnt_pos [N_STREAMS];
  // Reference model of arbiter and sequence queue
  int            rr_ptr = 0;
  int            grant_count = 0;
  int            pop_count = 0;
  int            beat_idx = 0;
  int            gq_stream [$];
  int            gq_beats [$];
  int            granted_beats = 0;
  int            raised_beats = 0;
  logic          rsp_fired = 1'b0;
  bit            rsp_enable = 1'b0;
  bit            rsp_bp = 1'b0;
  bit            sending = 1'b0;
  integer        seed = 32'he5c0_8ff0;
  // Descriptor expected on the stalled request channel
  mux_pkg::req_t held;
  int            held_stream;

  tb_clock tb_clock_i (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  user_mux_top #(
    .N_STREAMS     (N_STREAMS),
    .N_OUTSTANDING (N_OUTSTANDING)
  ) user_mux_top_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req_data  (s_req_data),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_data  (m_req_data),
    .s_rsp_valid (s_rsp_valid),
    .s_rsp_ready (s_rsp_ready),
    .s_rsp_data  (s_rsp_data),
    .m_rsp_valid (m_rsp_valid),
    .m_rsp_ready (m_rsp_ready),
    .m_rsp_last  (m_rsp_last),
    .m_rsp_data  (m_rsp_data)
  );

  // ------------------------------
  // Error reporting
  // ------------------------------
  task automatic end_in_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    $display("Error: %s", msg);
    end_in_failure();
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      end_in_failure();
    end
  endtask

  // ------------------------------
  // Cases
  // ------------------------------
  function automatic mux_pkg::req_t case_req(input int idx);
    mux_pkg::req_t r;
    r.vaddr = case_mem[5*idx+2];
    r.len   = case_mem[5*idx+1][15:0];
    r.wr    = case_mem[5*idx+3][0];
    return r;
  endfunction

  task automatic load_cases();
    int s;
    $readmemh("test/user_mux_cases.txt", case_mem);
    for (int i = 0; i < N_STREAMS; i++) begin
      n_sc[i]     = 0;
      send_pos[i] = 0;
      acc_pos[i]  = 0;
      gnt_pos[i]  = 0;
    end
    for (int i = 0; i < N_CASES; i++) begin
      if ($isunknown(case_mem[5*i+4])) begin
        report_error("cases file holds fewer cases than expected");
      end
      s = int'(case_mem[5*i]);
      if (s >= N_STREAMS) begin
        report_error("cases file names a stream that does not exist");
      end
      // Beats are (len - 1) / 8 + 1
      if (int'(case_mem[5*i+4]) != (int'(case_mem[5*i+1]) - 1) / 8 + 1) begin
        report_error("beat count in the cases file disagrees with its length");
      end
      sc[s][n_sc[s]] = i;
      n_sc[s]++;
    end
  endtask

  // ------------------------------
  // Reference model and checks
  // ------------------------------
  // First held stream from the pointer, -1 if none
  function automatic int next_grant_stream();
    int s;
    int idx;
    s = -1;
    for (int i = 0; i < N_STREAMS; i++) begin
      idx = (rr_ptr + i) % N_STREAMS;
      if (s < 0 && acc_pos[idx] > gnt_pos[idx]) begin
        s = idx;
      end
    end
    return s;
  endfunction

  task automatic observe_cycle();
    int            s;
    int            hs;
    bit            any_pend;
    mux_pkg::req_t exp_req;
    any_pend = 1'b0;
    for (int i = 0; i < N_STREAMS; i++) begin
      if (acc_pos[i] > gnt_pos[i]) begin
        any_pend = 1'b1;
      end
    end
    // Request offered only with a held descriptor and queue room
    check_value("m_req_valid", m_req_valid,
                any_pend && (grant_count - pop_count < N_OUTSTANDING));
    // Response routing follows the visible head entry
    rsp_fired = s_rsp_valid && s_rsp_ready;
    if (gq_stream.size() > 0) begin
      hs = gq_stream[0];
      check_value("s_rsp_ready", s_rsp_ready, m_rsp_ready[hs]);
      check_value("m_rsp_valid", m_rsp_valid, s_rsp_valid ? (1 << hs) : 0);
      check_value("m_rsp_last", m_rsp_last, (beat_idx == gq_beats[0] - 1) ? (1 << hs) : 0);
      if (rsp_fired) begin
        check_value("m_rsp_data", m_rsp_data, s_rsp_data);
        beat_idx++;
        if (beat_idx == gq_beats[0]) begin
          beat_idx = 0;
          pop_count++;
          void'(gq_stream.pop_front());
          void'(gq_beats.pop_front());
        end
      end
    end else begin
      check_value("s_rsp_ready", s_rsp_ready, 0);
      check_value("m_rsp_valid", m_rsp_valid, 0);
      check_value("m_rsp_last", m_rsp_last, 0);
    end
    // Grant goes to the first held stream from the pointer
    if (m_req_valid && m_req_ready) begin
      s = next_grant_stream();
      exp_req = case_req(sc[s][gnt_pos[s]]);
      check_value("m_req_data.vaddr", m_req_data.vaddr, exp_req.vaddr);
      check_value("m_req_data.len", m_req_data.len, exp_req.len);
      check_value("m_req_data.wr", m_req_data.wr, exp_req.wr);
      gq_stream.push_back(s);
      gq_beats.push_back(int'(case_mem[5*sc[s][gnt_pos[s]]+4]));
      granted_beats += int'(case_mem[5*sc[s][gnt_pos[s]]+4]);
      gnt_pos[s]++;
      grant_count++;
      // Pointer steps once per grant
      rr_ptr = (rr_ptr + 1) % N_STREAMS;
    end
    // Descriptors taken by the decode stages
    for (int i = 0; i < N_STREAMS; i++) begin
      if (s_req_valid[i] && s_req_ready[i]) begin
        acc_pos[i]++;
      end
    end
  endtask

  // Mid-cycle sampling, inputs move 1 ns after the rising edge
  always @(negedge aclk) begin
    if (aresetn === 1'b1) begin
      observe_cycle();
    end
  end

  // ------------------------------
  // Response source
  // ------------------------------
  initial begin
    s_rsp_valid = 1'b0;
    s_rsp_data  = '0;
    m_rsp_ready = '1;
    forever begin
      @(posedge aclk);
      #1;
      if (rsp_fired) begin
        s_rsp_valid = 1'b0;
      end
      // Random gaps, only beats that are owed
      if (!s_rsp_valid && rsp_enable && raised_beats < granted_beats &&
          ($random(seed) & 3) != 0) begin
        s_rsp_valid = 1'b1;
        s_rsp_data  = {$random(seed), $random(seed)};
        raised_beats++;
      end
      m_rsp_ready = rsp_bp ? $random(seed) : '1;
    end
  end

  // ------------------------------
  // Stimulus and waits
  // ------------------------------
  // Present cases up to index last on their streams
  task automatic send_cases(input int last);
    int                   cycles;
    bit                   busy;
    logic [N_STREAMS-1:0] fired;
    cycles = 0;
    busy   = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int i = 0; i < N_STREAMS; i++) begin
        if (send_pos[i] < n_sc[i] && sc[i][send_pos[i]] <= last) begin
          s_req_valid[i] = 1'b1;
          s_req_data[i]  = case_req(sc[i][send_pos[i]]);
          busy           = 1'b1;
        end else begin
          s_req_valid[i] = 1'b0;
        end
      end
      if (busy) begin
        @(negedge aclk);
        fired = s_req_valid & s_req_ready;
        @(posedge aclk);
        #1;
        for (int i = 0; i < N_STREAMS; i++) begin
          if (fired[i]) begin
            send_pos[i]++;
          end
        end
        cycles++;
        if (cycles > TIMEOUT) begin
          report_error("request descriptors were not accepted in time");
        end
      end
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (aresetn !== 1'b1) begin
      @(posedge aclk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("reset was never released");
      end
    end
  endtask

  task automatic wait_req_valid();
    int cycles;
    cycles = 0;
    while (!m_req_valid) begin
      @(posedge aclk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("no request appeared on the shared channel");
      end
    end
  endtask

  task automatic wait_grants(input int n);
    int cycles;
    cycles = 0;
    while (grant_count < n) begin
      @(posedge aclk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("expected grants did not happen in time");
      end
    end
  endtask

  // All n cases granted and every response delivered
  task automatic wait_drained(input int n);
    int cycles;
    cycles = 0;
    while (grant_count < n || gq_stream.size() > 0) begin
      @(posedge aclk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("responses did not drain in time");
      end
    end
  endtask

  task automatic wait_send_done();
    int cycles;
    cycles = 0;
    while (sending) begin
      @(posedge aclk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("request stimulus did not finish in time");
      end
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    s_req_valid = '0;
    s_req_data  = '0;
    m_req_ready = 1'b0;
    load_cases();
    wait_reset_release();
    // Idle outputs, decode stages empty
    check_value("s_req_ready", s_req_ready, {N_STREAMS{1'b1}});
    check_value("m_req_valid", m_req_valid, 0);
    check_value("s_rsp_ready", s_rsp_ready, 0);
    check_value("m_rsp_valid", m_rsp_valid, 0);

    // One descriptor per stream while the request channel stalls
    send_cases(3);
    wait_req_valid();
    held_stream = next_grant_stream();
    if (held_stream < 0) begin
      report_error("request offered while no descriptor was taken");
    end
    held = case_req(sc[held_stream][gnt_pos[held_stream]]);
    repeat (6) begin
      @(posedge aclk);
      #1;
      check_value("m_req_valid", m_req_valid, 1);
      check_value("m_req_data.vaddr", m_req_data.vaddr, held.vaddr);
      check_value("m_req_data.len", m_req_data.len, held.len);
      check_value("m_req_data.wr", m_req_data.wr, held.wr);
    end

    // Full rounds with stream back-pressure on the responses
    rsp_enable  = 1'b1;
    rsp_bp      = 1'b1;
    m_req_ready = 1'b1;
    send_cases(11);
    wait_drained(12);

    // Queue fills without responses, grants must stop
    rsp_enable = 1'b0;
    rsp_bp     = 1'b0;
    sending    = 1'b1;
    fork
      begin
        send_cases(N_CASES - 1);
        sending = 1'b0;
      end
    join_none
    wait_grants(12 + N_OUTSTANDING);
    repeat (10) begin
      @(posedge aclk);
      #1;
      check_value("m_req_valid", m_req_valid, 0);
    end
    rsp_enable = 1'b1;
    wait_send_done();
    wait_drained(N_CASES);

    // All stages idle again after the last response
    check_value("s_req_ready", s_req_ready, {N_STREAMS{1'b1}});
    check_value("m_req_valid", m_req_valid, 0);
    check_value("s_rsp_ready", s_rsp_ready, 0);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Testbench clock and reset generator
// 20 ns clock, active-low reset held for the first cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // Release 1 ns after a rising edge, like all other inputs
  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    aresetn = 1'b1;
  end

endmodule

`default_nettype wire

//--- source/user_mux_top.sv
// Top level of the request multiplexer
// Per stream decode, round-robin arbiter, sequence FIFO
// and response data router
`timescale 1ns/1ps
`default_nettype none

module user_mux_top #(
  parameter int N_STREAMS     = 4,
  parameter int N_OUTSTANDING = 8
) (
  input  wire                                 aclk,
  input  wire                                 aresetn,

  // Stream requests
  input  wire [N_STREAMS-1:0]                 s_req_valid,
  output logic [N_STREAMS-1:0]                s_req_ready,
  input  wire mux_pkg::req_t [N_STREAMS-1:0]  s_req_data,

  // Shared request channel
  output logic                                m_req_valid,
  input  wire                                 m_req_ready,
  output mux_pkg::req_t                       m_req_data,

  // Shared response data
  input  wire                                 s_rsp_valid,
  output logic                                s_rsp_ready,
  input  wire mux_pkg::data_t                 s_rsp_data,

  // Stream responses
  output logic [N_STREAMS-1:0]                m_rsp_valid,
  input  wire [N_STREAMS-1:0]                 m_rsp_ready,
  output logic [N_STREAMS-1:0]                m_rsp_last,
  output mux_pkg::data_t                      m_rsp_data
);

  localparam int ID_BITS = (N_STREAMS > 1) ? $clog2(N_STREAMS) : 1;

  // Decode to arbiter
  logic [N_STREAMS-1:0]           dec_valid;
  logic [N_STREAMS-1:0]           dec_ready;
  mux_pkg::dreq_t [N_STREAMS-1:0] dec_data;

  // Arbiter to queue
  logic               push_valid;
  logic               push_ready;
  logic [ID_BITS-1:0] push_id;
  mux_pkg::blen_t     push_beats;

  // Queue head to router
  logic               head_valid;
  logic               head_ready;
  logic [ID_BITS-1:0] head_id;
  mux_pkg::blen_t     head_beats;

  // ------------------------------
  // Decode stages
  // ------------------------------
  for (genvar i = 0; i < N_STREAMS; i++) begin : g_dec
    req_decode req_decode_i (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (s_req_valid[i]),
      .s_ready (s_req_ready[i]),
      .s_data  (s_req_data[i]),
      .m_valid (dec_valid[i]),
      .m_ready (dec_ready[i]),
      .m_data  (dec_data[i])
    );
  end

  // ------------------------------
  // Arbiter, queue and router
  // ------------------------------
  rr_arbiter #(
    .N_STREAMS (N_STREAMS)
  ) rr_arbiter_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .s_valid   (dec_valid),
    .s_ready   (dec_ready),
    .s_data    (dec_data),
    .m_valid   (m_req_valid),
    .m_ready   (m_req_ready),
    .m_data    (m_req_data),
    .seq_valid (push_valid),
    .seq_ready (push_ready),
    .seq_id    (push_id),
    .seq_beats (push_beats)
  );

  seq_queue #(
    .N_STREAMS     (N_STREAMS),
    .N_OUTSTANDING (N_OUTSTANDING)
  ) seq_queue_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (push_valid),
    .s_ready (push_ready),
    .s_id    (push_id),
    .s_beats (push_beats),
    .m_valid (head_valid),
    .m_ready (head_ready),
    .m_id    (head_id),
    .m_beats (head_beats)
  );

  data_router #(
    .N_STREAMS (N_STREAMS)
  ) data_router_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .seq_valid (head_valid),
    .seq_ready (head_ready),
    .seq_id    (head_id),
    .seq_beats (head_beats),
    .s_valid   (s_rsp_valid),
    .s_ready   (s_rsp_ready),
    .s_data    (s_rsp_data),
    .m_valid   (m_rsp_valid),
    .m_ready   (m_rsp_ready),
    .m_data    (m_rsp_data),
    .m_last    (m_rsp_last)
  );

endmodule

`default_nettype wire

//--- source/data_router.sv
// Response data router
// Steers beats to the stream of the head sequence entry,
// counts beats and marks the last one
`timescale 1ns/1ps
`default_nettype none

module data_router #(
  parameter  int N_STREAMS = 4,
  localparam int ID_BITS   = (N_STREAMS > 1) ? $clog2(N_STREAMS) : 1
) (
  input  wire                   aclk,
  input  wire                   aresetn,

  // Head sequence entry
  input  wire                   seq_valid,
  output logic                  seq_ready,
  input  wire [ID_BITS-1:0]     seq_id,
  input  wire mux_pkg::blen_t   seq_beats,

  // Shared response data in
  input  wire                   s_valid,
  output logic                  s_ready,
  input  wire mux_pkg::data_t   s_data,

  // Per stream response out
  output logic [N_STREAMS-1:0]  m_valid,
  input  wire [N_STREAMS-1:0]   m_ready,
  output mux_pkg::data_t        m_data,
  output logic [N_STREAMS-1:0]  m_last
);

  // Beats already passed for the head entry
  mux_pkg::blen_t beat_cnt;
  // Current beat closes the entry
  logic           last_beat;
  // Beat transfer on the routed stream
  logic           beat_xfer;

  assign last_beat = (beat_cnt == seq_beats);

  // ------------------------------
  // Routing
  // ------------------------------
  // Data is shared, valid and last go to one stream
  assign m_data = s_data;

  always_comb begin
    m_valid = '0;
    m_last  = '0;
    if (seq_valid) begin
      m_valid[seq_id] = s_valid;
      m_last[seq_id]  = last_beat;
    end
  end

  // Stalled owner stalls the shared input
  assign s_ready   = seq_valid && m_ready[seq_id];
  assign beat_xfer = s_valid && s_ready;
  // Pop on the final beat
  assign seq_ready = beat_xfer && last_beat;

  // ------------------------------
  // Beat counter
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_cnt <= '0;
    end else if (beat_xfer) begin
      if (last_beat) begin
        // Next entry starts from zero
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/seq_queue.sv
// Sequence FIFO of granted requests
// Stream id and beat count, waiting for the response data
`timescale 1ns/1ps
`default_nettype none

module seq_queue #(
  parameter  int N_STREAMS     = 4,
  parameter  int N_OUTSTANDING = 8,
  localparam int ID_BITS       = (N_STREAMS > 1) ? $clog2(N_STREAMS) : 1
) (
  input  wire                  aclk,
  input  wire                  aresetn,

  // Push side
  input  wire                  s_valid,
  output logic                 s_ready,
  input  wire [ID_BITS-1:0]    s_id,
  input  wire mux_pkg::blen_t  s_beats,

  // Head entry
  output logic                 m_valid,
  input  wire                  m_ready,
  output logic [ID_BITS-1:0]   m_id,
  output mux_pkg::blen_t       m_beats
);

  localparam int PTR_BITS = (N_OUTSTANDING > 1) ? $clog2(N_OUTSTANDING) : 1;
  localparam int CNT_BITS = $clog2(N_OUTSTANDING + 1);
  localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(N_OUTSTANDING - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(N_OUTSTANDING);

  // One stored entry
  typedef struct packed {
    logic [ID_BITS-1:0] id;
    mux_pkg::blen_t     beats;
  } seq_t;

  seq_t                mem [N_OUTSTANDING];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  assign s_ready = (count != FULL_CNT);
  assign m_valid = (count != '0);
  assign push    = s_valid && s_ready;
  assign pop     = m_valid && m_ready;

  // Head straight from storage
  assign m_id    = mem[rd_ptr].id;
  assign m_beats = mem[rd_ptr].beats;

  // ------------------------------
  // Pointers and fill level
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together keep the level
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= '{id: s_id, beats: s_beats};
    end
  end

endmodule

`default_nettype wire

//--- source/rr_arbiter.sv
// Round-robin arbiter of the decoded stream requests
// Grants one stream onto the shared request output and
// pushes the matching sequence entry
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
  parameter  int N_STREAMS = 4,
  localparam int ID_BITS   = (N_STREAMS > 1) ? $clog2(N_STREAMS) : 1
) (
  input  wire                                  aclk,
  input  wire                                  aresetn,

  // Decoded requests, one per stream
  input  wire [N_STREAMS-1:0]                  s_valid,
  output logic [N_STREAMS-1:0]                 s_ready,
  input  wire mux_pkg::dreq_t [N_STREAMS-1:0]  s_data,

  // Shared request output
  output logic                                 m_valid,
  input  wire                                  m_ready,
  output mux_pkg::req_t                        m_data,

  // Sequence entry push
  output logic                                 seq_valid,
  input  wire                                  seq_ready,
  output logic [ID_BITS-1:0]                   seq_id,
  output mux_pkg::blen_t                       seq_beats
);

  // Highest stream id, where the pointer wraps
  localparam logic [ID_BITS-1:0] LAST_ID = ID_BITS'(N_STREAMS - 1);

  // Stream searched first
  logic [ID_BITS-1:0] rr_ptr;
  // Search result
  logic               found;
  logic [ID_BITS-1:0] gnt_id;
  // Candidate index, wrapped
  int                 idx;

  // ------------------------------
  // Grant search
  // ------------------------------
  always_comb begin
    found  = 1'b0;
    gnt_id = '0;
    idx    = 0;
    // Walk from the pointer, first valid wins
    for (int i = 0; i < N_STREAMS; i++) begin
      idx = int'(rr_ptr) + i;
      if (idx >= N_STREAMS) begin
        idx = idx - N_STREAMS;
      end
      if (!found && s_valid[idx]) begin
        found  = 1'b1;
        gnt_id = ID_BITS'(idx);
      end
    end
  end

  // Only while the queue can take the entry
  assign m_valid = found && seq_ready;

  // Ready back to the granted stream only
  always_comb begin
    s_ready         = '0;
    s_ready[gnt_id] = found && m_ready && seq_ready;
  end

  // Granted stream's data
  assign m_data    = s_data[gnt_id].req;
  assign seq_id    = gnt_id;
  assign seq_beats = s_data[gnt_id].n_beats;
  // Push together with the request transfer
  assign seq_valid = m_valid && m_ready;

  // ------------------------------
  // Round-robin pointer
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (m_valid && m_ready) begin
      // One step per granted transfer
      if (rr_ptr == LAST_ID) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= rr_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/req_decode.sv
// Decode stage of one request stream
// Holds one descriptor and adds its beat count
`timescale 1ns/1ps
`default_nettype none

module req_decode (
  input  wire                 aclk,
  input  wire                 aresetn,

  // Descriptor from the stream
  input  wire                 s_valid,
  output logic                s_ready,
  input  wire mux_pkg::req_t  s_data,

  // Decoded descriptor toward the arbiter
  output logic                m_valid,
  input  wire                 m_ready,
  output mux_pkg::dreq_t      m_data
);

  // Stage holds a descriptor
  logic full;
  // Byte length minus one, before the beat shift
  mux_pkg::len_t len_m1;

  assign len_m1 = s_data.len - mux_pkg::len_t'(1);

  // Empty slot, or the held one leaves this cycle
  assign s_ready = !full || m_ready;
  assign m_valid = full;

  // ------------------------------
  // Occupancy
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      full <= 1'b0;
    end else if (s_valid && s_ready) begin
      // Refill, also when the old one leaves
      full <= 1'b1;
    end else if (m_ready) begin
      full <= 1'b0;
    end
  end

  // ------------------------------
  // Descriptor and beat count
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      m_data.req     <= s_data;
      // Beats minus one from the byte length
      m_data.n_beats <= mux_pkg::blen_t'(len_m1 >> mux_pkg::BEAT_LOG);
    end
  end

endmodule

`default_nettype wire

//--- source/mux_pkg.sv
// Shared definitions of the request multiplexer
// Beat geometry, vector typedefs and request descriptors
`default_nettype none

package mux_pkg;

  // ------------------------------
  // Beat geometry
  // ------------------------------
  // One response data beat
  localparam int DATA_BITS  = 64;
  localparam int BEAT_BYTES = DATA_BITS / 8;
  // Byte offset bits within a beat
  localparam int BEAT_LOG   = $clog2(BEAT_BYTES);

  // ------------------------------
  // Request fields
  // ------------------------------
  localparam int LEN_BITS  = 16;
  localparam int ADDR_BITS = 48;
  // Beats minus one fit in what is left after the offset bits
  localparam int BLEN_BITS = LEN_BITS - BEAT_LOG;

  typedef logic [LEN_BITS-1:0]  len_t;
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [BLEN_BITS-1:0] blen_t;
  typedef logic [DATA_BITS-1:0] data_t;

  // Request descriptor as sent by a stream
  typedef struct packed {
    addr_t vaddr;
    len_t  len;
    logic  wr;
  } req_t;

  // Descriptor after decode
  typedef struct packed {
    req_t  req;
    // Number of beats minus one
    blen_t n_beats;
  } dreq_t;

endpackage

`default_nettype wire
